//--- Bender.yml
package:
  name: tetris_top

sources:
  - hdl/tetris_pkg.sv
  - hdl/video_pkg.sv
  - hdl/button_debounce.sv
  - hdl/drop_timer.sv
  - hdl/tetris_engine.sv
  - hdl/vga_timing.sv
  - hdl/pixel_compositor.sv
  - hdl/game_regs.sv
  - hdl/tetris_top.sv
  - target: simulation
    files:
      - bench/tetris_top_tb.sv

//--- bench/tetris_top_tb.sv
`default_nettype none
`timescale 1ns/1ps

module tetris_top_tb;

  import tetris_pkg::*;
  import video_pkg::*;

  // ==========================================================
  // Run limits and button codes
  // ==========================================================

  localparam int DEBOUNCE     = 4;
  localparam int TICK         = 64;
  // One VGA frame in pixel clocks
  localparam int FRAME_CYCLES = 800 * 525;
  // Roughly twenty pieces of twenty ticks each
  localparam int GAME_CYCLES  = 20 * 20 * TICK;
  // Sync test and pixel test take up to two frames each
  // One frame spare
  localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + 2 * GAME_CYCLES;
  // Status polls allowed in one wait
  // A poll takes two cycles
  localparam int POLL_LIMIT   = 2 * 20 * TICK;

  localparam int BTN_LEFT  = 0;
  localparam int BTN_RIGHT = 1;
  localparam int BTN_START = 2;

  // Expected colours as red, green and blue bits
  localparam rgb_t BLACK = 3'b000;
  localparam rgb_t GREEN = 3'b010;
  localparam rgb_t WHITE = 3'b111;

  logic        clk;
  logic        rst_n;
  logic        btn_left;
  logic        btn_right;
  logic        btn_start;
  logic        btn_speed;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [4:0]  wb_adr;
  logic [31:0] wb_dat;
  logic        wb_ack;
  logic        red;
  logic        green;
  logic        blue;
  logic        hsync;
  logic        vsync;

  string  test_name;
  integer cycles;
  // Raster index on the colour pins, counted from a vsync fall
  integer raster;

  tetris_top #(
    .DEBOUNCE_CYCLES(DEBOUNCE),
    .TICK_CYCLES(TICK)
  ) dut_i (
    .clk_i(clk), .rst_n_i(rst_n),
    .btn_left_i(btn_left), .btn_right_i(btn_right),
    .btn_start_i(btn_start), .btn_speed_i(btn_speed),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_o(wb_dat), .wb_ack_o(wb_ack),
    .red_o(red), .green_o(green), .blue_o(blue), .hsync_o(hsync), .vsync_o(vsync)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: the tests ran past %0d cycles in %s", TIMEOUT_CYCLES, test_name);
        stop_failed();
      end
    end
  end

  task automatic stop_failed();
    $display("Done: errors found");
    $fatal(1);
  endtask

  // ==========================================================
  // Compare tasks
  // ==========================================================

  task automatic check_row(input string what, input row_bits_t exp, input row_bits_t act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %03h, got %03h", test_name, what, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_score(input string what, input score_t exp, input score_t act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %0d, got %0d", test_name, what, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_state(input string what, input game_state_e exp,
                             input game_state_e act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %s, got %s (%0d)", test_name, what,
               exp.name(), act.name(), act);
      stop_failed();
    end
  endtask

  task automatic check_col(input string what, input col_t exp, input col_t act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %0d, got %0d", test_name, what, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_pos(input string what, input piece_pos_t exp, input piece_pos_t act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected row %0d col %0d, got row %0d col %0d",
               test_name, what, exp.row, exp.col, act.row, act.col);
      stop_failed();
    end
  endtask

  task automatic check_rgb(input string what, input rgb_t exp, input rgb_t act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected rgb %03b, got %03b", test_name, what, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_count(input string what, input integer exp, input integer act);
    if (act !== exp) begin
      $display("ERROR %s %s: expected %0d, got %0d", test_name, what, exp, act);
      stop_failed();
    end
  endtask

  // ==========================================================
  // Bus and button helpers
  // ==========================================================

  // Single read with data taken while ack is high
  task automatic wb_read(input logic [4:0] adr, output logic [31:0] data);
    integer waited;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    waited = 0;
    do begin
      @(negedge clk);
      waited = waited + 1;
      if (waited > 4) begin
        $display("Bus read of word %0d got no ack in %s", adr, test_name);
        stop_failed();
      end
    end while (wb_ack !== 1'b1);
    data   = wb_dat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // Status word decoded by the register map
  task automatic read_status(output game_state_e st, output score_t sc,
                             output piece_pos_t pos);
    logic [31:0] d;
    wb_read(5'd0, d);
    st      = game_state_e'(d[2:0]);
    sc      = d[12:3];
    pos.row = d[17:13];
    pos.col = d[21:18];
  endtask

  task automatic set_button(input int btn, input logic val);
    case (btn)
      BTN_LEFT:  btn_left = val;
      BTN_RIGHT: btn_right = val;
      default:   btn_start = val;
    endcase
  endtask

  // Hold for 8 cycles then release for 8
  task automatic press(input int btn);
    @(negedge clk);
    set_button(btn, 1'b1);
    repeat (8) @(negedge clk);
    set_button(btn, 1'b0);
    repeat (8) @(negedge clk);
  endtask

  task automatic wait_state(input game_state_e want);
    game_state_e st;
    score_t      sc;
    piece_pos_t  pos;
    integer      polls;
    polls = 0;
    read_status(st, sc, pos);
    while (st != want) begin
      polls = polls + 1;
      if (polls > POLL_LIMIT) begin
        $display("Engine never reached state %s in %s", want.name(), test_name);
        stop_failed();
      end
      read_status(st, sc, pos);
    end
  endtask

  // Returns just after a gravity step so that a press cannot meet a tick
  task automatic wait_row_step();
    game_state_e st;
    score_t      sc;
    piece_pos_t  pos;
    row_t        start_row;
    integer      polls;
    polls = 0;
    read_status(st, sc, pos);
    start_row = pos.row;
    while (pos.row == start_row) begin
      polls = polls + 1;
      if (polls > POLL_LIMIT) begin
        $display("Falling piece stopped moving down in %s", test_name);
        stop_failed();
      end
      read_status(st, sc, pos);
    end
  endtask

  task automatic move_piece(input int btn, input int times);
    for (int i = 0; i < times; i++) begin
      wait_row_step();
      press(btn);
    end
  endtask

  // Current piece lands and the next one falls
  task automatic drop_piece();
    wait_state(CLEAR);
    wait_state(FALL);
  endtask

  // Square piece footprint in one row
  function automatic row_bits_t pair(input int col);
    return row_bits_t'(2'b11) << col;
  endfunction

  task automatic expect_status(input game_state_e st_exp, input score_t sc_exp);
    game_state_e st;
    score_t      sc;
    piece_pos_t  pos;
    read_status(st, sc, pos);
    check_state("state", st_exp, st);
    check_score("score", sc_exp, sc);
  endtask

  task automatic expect_pos(input int row, input int col);
    game_state_e st;
    score_t      sc;
    piece_pos_t  pos;
    piece_pos_t  exp;
    exp.row = row_t'(row);
    exp.col = col_t'(col);
    read_status(st, sc, pos);
    check_pos("piece position", exp, pos);
  endtask

  task automatic expect_col(input int col);
    game_state_e st;
    score_t      sc;
    piece_pos_t  pos;
    read_status(st, sc, pos);
    check_col("piece column", col_t'(col), pos.col);
  endtask

  // Rows sit at word row+1
  task automatic check_field(input playfield_t exp);
    logic [31:0] d;
    for (int r = 0; r < 20; r++) begin
      wb_read(5'(r + 1), d);
      check_row($sformatf("row %0d", r), exp[r], d[9:0]);
    end
  endtask

  // Cycles low and cycles between falling edges on the falling clock
  function automatic logic sync_level(input logic use_v);
    return use_v ? vsync : hsync;
  endfunction

  task automatic sync_pulse(input logic use_v, output integer low_len, output integer period);
    integer n;
    while (sync_level(use_v) !== 1'b1) @(negedge clk);
    while (sync_level(use_v) !== 1'b0) @(negedge clk);
    n = 0;
    while (sync_level(use_v) === 1'b0) begin
      @(negedge clk);
      n = n + 1;
    end
    low_len = n;
    while (sync_level(use_v) !== 1'b0) begin
      @(negedge clk);
      n = n + 1;
    end
    period = n;
  endtask

  // First low vsync sample shows line 490, pixel 0
  task automatic find_frame();
    while (vsync !== 1'b1) @(negedge clk);
    while (vsync !== 1'b0) @(negedge clk);
    raster = 490 * 800;
  endtask

  // Steps forward along the raster to pixel (x, y)
  task automatic expect_pixel(input string what, input int x, input int y, input rgb_t exp);
    integer target;
    rgb_t   act;
    target = y * 800 + x;
    repeat ((target - raster + FRAME_CYCLES) % FRAME_CYCLES) @(negedge clk);
    raster = target;
    act    = {red, green, blue};
    check_rgb(what, exp, act);
  endtask

  // ==========================================================
  // Tests
  // ==========================================================

  task automatic test_reset();
    logic [31:0] d;
    test_name = "reset";
    check_count("hsync level", 1, hsync);
    check_count("vsync level", 1, vsync);
    check_count("ack level", 0, wb_ack);
    expect_status(IDLE, 10'd0);
    check_field('0);
    wb_read(5'd21, d);
    check_count("unmapped word", 0, d);
  endtask

  task automatic test_vga();
    integer low_len;
    integer period;
    test_name = "vga";
    sync_pulse(1'b0, low_len, period);
    check_count("hsync low", 96, low_len);
    check_count("hsync period", 800, period);
    sync_pulse(1'b1, low_len, period);
    check_count("vsync low", 1600, low_len);
    check_count("vsync period", 420000, period);
  endtask

  task automatic test_drop();
    playfield_t exp;
    test_name = "drop";
    press(BTN_START);
    wait_state(FALL);
    expect_pos(0, 4);
    drop_piece();
    expect_pos(0, 4);
    exp     = '0;
    exp[18] = pair(4);
    exp[19] = pair(4);
    check_field(exp);
    expect_status(FALL, 10'd0);
  endtask

  task automatic test_move();
    playfield_t exp;
    test_name = "move";
    move_piece(BTN_LEFT, 4);
    expect_col(0);
    // Wall stops further moves
    move_piece(BTN_LEFT, 2);
    expect_col(0);
    drop_piece();
    exp     = '0;
    exp[18] = pair(0) | pair(4);
    exp[19] = pair(0) | pair(4);
    check_field(exp);
    expect_status(FALL, 10'd0);
  endtask

  task automatic test_clear();
    playfield_t exp;
    test_name = "clear";
    exp     = '0;
    exp[18] = pair(0) | pair(4);
    move_piece(BTN_LEFT, 2);
    drop_piece();
    exp[18] = exp[18] | pair(2);
    exp[19] = exp[18];
    check_field(exp);
    move_piece(BTN_RIGHT, 2);
    drop_piece();
    exp[18] = exp[18] | pair(6);
    exp[19] = exp[18];
    check_field(exp);
    // Last gap filled and both rows go
    move_piece(BTN_RIGHT, 4);
    drop_piece();
    expect_pos(0, 4);
    check_field('0);
    expect_status(FALL, 10'd2);
  endtask

  task automatic test_game_over();
    playfield_t exp;
    test_name = "game over";
    // Nine pieces fill rows 2 to 19
    // The tenth locks at the top and the next spawn collides
    repeat (9) drop_piece();
    wait_state(OVER);
    for (int r = 0; r < 20; r++) begin
      exp[r] = pair(4);
    end
    check_field(exp);
    expect_status(OVER, 10'd2);
    // Stacked cells white in OVER and an 8 pixel bar for score 2
    find_frame();
    expect_pixel("empty cell", 248, 88, BLACK);
    expect_pixel("stacked cell", 312, 88, WHITE);
    expect_pixel("score bar", 4, 444, GREEN);
    expect_pixel("past score bar", 8, 444, BLACK);
    press(BTN_START);
    wait_state(FALL);
    expect_pos(0, 4);
    check_field('0);
    expect_status(FALL, 10'd0);
  endtask

  initial begin
    test_name = "init";
    rst_n     = 1'b0;
    btn_left  = 1'b0;
    btn_right = 1'b0;
    btn_start = 1'b0;
    btn_speed = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_vga();
    test_drop();
    test_move();
    test_clear();
    test_game_over();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/button_debounce.sv
`default_nettype none
`timescale 1ns/1ps

module button_debounce #(
  parameter int DEBOUNCE_CYCLES = 250000
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic pad_i,
  output logic press_o,
  output logic level_o
);

  localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);
  typedef logic [CW-1:0] count_t;

  // Two-flop synchroniser, bit 1 is the safe copy
  logic [1:0] sync_q;
  // Cycles the synchronised pad has differed from the level
  count_t     count_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q  <= '0;
      count_q <= '0;
      level_o <= 1'b0;
      press_o <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], pad_i};
      press_o <= 1'b0;
      if (sync_q[1] == level_o) begin
        // Bounce back, start over
        count_q <= '0;
      end else if (count_q == count_t'(DEBOUNCE_CYCLES - 1)) begin
        // Stable long enough
        count_q <= '0;
        level_o <= sync_q[1];
        // Pulse only on the rising edge
        press_o <= sync_q[1];
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/drop_timer.sv
`default_nettype none
`timescale 1ns/1ps

module drop_timer #(
  parameter int TICK_CYCLES = 12500000
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               run_i,
  input  logic               speed_up_i,
  input  tetris_pkg::score_t score_i,
  output logic               tick_o
);

  localparam int CW = $clog2(TICK_CYCLES + 1);
  typedef logic [CW-1:0] count_t;

  logic [1:0] level;
  logic [2:0] shift;
  count_t     reload;
  count_t     count_q;

  // One level per four cleared rows, capped at three
  assign level  = (score_i[9:2] > 8'd3) ? 2'd3 : score_i[3:2];
  // Held speed-up gives a further quarter
  assign shift  = {1'b0, level} + (speed_up_i ? 3'd2 : 3'd0);
  assign reload = count_t'(TICK_CYCLES) >> shift;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
      tick_o  <= 1'b0;
    end else if (!run_i) begin
      // Hold in reload outside FALL
      count_q <= reload - 1'b1;
      tick_o  <= 1'b0;
    end else if (count_q == '0) begin
      count_q <= reload - 1'b1;
      tick_o  <= 1'b1;
    end else begin
      count_q <= count_q - 1'b1;
      tick_o  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/game_regs.sv
`default_nettype none
`timescale 1ns/1ps

module game_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [4:0]               wb_adr_i,
  output logic [31:0]              wb_dat_o,
  output logic                     wb_ack_o,
  input  tetris_pkg::playfield_t   field_i,
  input  tetris_pkg::game_status_t status_i
);

  import tetris_pkg::*;

  logic        req;
  logic [31:0] rd_data;

  // New cycle, never two acks back to back
  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

  // Word 0 status, words 1 to 20 field rows
  always_comb begin
    rd_data = '0;
    if (wb_adr_i == 5'd0) begin
      rd_data = 32'(status_i);
    end else if (wb_adr_i <= 5'(ROWS)) begin
      rd_data = 32'(field_i[wb_adr_i - 5'd1]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;
    end
  end

  // Writes get an ack and zero data
  always_ff @(posedge clk_i) begin
    if (req) begin
      wb_dat_o <= wb_we_i ? '0 : rd_data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/pixel_compositor.sv
`default_nettype none
`timescale 1ns/1ps

module pixel_compositor (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  video_pkg::vga_sync_t     sync_i,
  input  tetris_pkg::playfield_t   field_i,
  input  tetris_pkg::game_status_t status_i,
  output video_pkg::rgb_t          rgb_o,
  output logic                     hsync_o,
  output logic                     vsync_o
);

  import tetris_pkg::*;
  import video_pkg::*;

  // Screen layout, cells are 16x16
  localparam pix_coord_t GRID_X0 = 10'd240;
  localparam pix_coord_t GRID_X1 = 10'd400;
  localparam pix_coord_t GRID_Y0 = 10'd80;
  localparam pix_coord_t GRID_Y1 = 10'd400;
  localparam pix_coord_t BAR_Y0  = 10'd440;
  localparam pix_coord_t BAR_Y1  = 10'd448;

  pix_coord_t dx;
  pix_coord_t dy;
  row_t       cell_row;
  col_t       cell_col;
  logic       in_grid;
  logic       in_bar;
  logic       locked;
  logic       piece;
  rgb_t       colour;

  always_comb begin
    // Offset into the grid
    dx       = sync_i.x - GRID_X0;
    dy       = sync_i.y - GRID_Y0;
    cell_col = dx[7:4];
    cell_row = dy[8:4];
    in_grid  = sync_i.visible && (sync_i.x >= GRID_X0) && (sync_i.x < GRID_X1)
            && (sync_i.y >= GRID_Y0) && (sync_i.y < GRID_Y1);
    // Four pixels per point
    in_bar   = sync_i.visible && (sync_i.y >= BAR_Y0) && (sync_i.y < BAR_Y1)
            && ({2'b00, sync_i.x} < {status_i.score, 2'b00});
    locked   = in_grid && field_i[cell_row][cell_col];
    // Falling piece shown until it merges into the field
    piece    = in_grid && (status_i.state inside {FALL, LOCK})
            && ((cell_row == status_i.pos.row) || (cell_row == status_i.pos.row + 1'b1))
            && ((cell_col == status_i.pos.col) || (cell_col == status_i.pos.col + 1'b1));
    // Score bar on top of everything
    if (in_bar) begin
      colour = RGB_GREEN;
    end else if (locked && status_i.state == OVER) begin
      colour = RGB_WHITE;
    end else if (piece) begin
      colour = RGB_RED;
    end else if (locked) begin
      colour = RGB_CYAN;
    end else begin
      colour = RGB_BLACK;
    end
  end

  // Colour and syncs leave together
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rgb_o   <= RGB_BLACK;
      hsync_o <= 1'b1;
      vsync_o <= 1'b1;
    end else begin
      rgb_o   <= colour;
      hsync_o <= sync_i.hsync;
      vsync_o <= sync_i.vsync;
    end
  end

endmodule

`default_nettype wire

//--- hdl/tetris_engine.sv
`default_nettype none
`timescale 1ns/1ps

module tetris_engine (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     start_i,
  input  logic                     left_i,
  input  logic                     right_i,
  input  logic                     tick_i,
  output tetris_pkg::playfield_t   field_o,
  output tetris_pkg::game_status_t status_o
);

  import tetris_pkg::*;

  game_state_e state_q;
  playfield_t  field_q;
  score_t      score_q;
  piece_pos_t  pos_q;
  // Row under test during CLEAR
  row_t        clr_row_q;

  // 2x2 piece at (r, c) lies within the walls on free cells
  function automatic logic fits(playfield_t f, row_t r, col_t c);
    logic ok;
    ok = (r <= row_t'(ROWS - 2)) && (c <= col_t'(COLS - 2));
    if (ok) begin
      ok = !(f[r][c] | f[r][c + 1] | f[r + 1][c] | f[r + 1][c + 1]);
    end
    return ok;
  endfunction

  // ==========================================================
  // Game FSM
  // ==========================================================

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      field_q   <= '0;
      score_q   <= '0;
      pos_q     <= '0;
      clr_row_q <= '0;
    end else begin
      unique case (state_q)
        IDLE, OVER: begin
          // New game wipes field and score
          if (start_i) begin
            field_q <= '0;
            score_q <= '0;
            state_q <= SPAWN;
          end
        end
        SPAWN: begin
          if (fits(field_q, '0, SPAWN_COL)) begin
            pos_q.row <= '0;
            pos_q.col <= SPAWN_COL;
            state_q   <= FALL;
          end else begin
            // Stack reached the top
            state_q <= OVER;
          end
        end
        FALL: begin
          // Gravity wins over a move in the same cycle
          if (tick_i) begin
            if (fits(field_q, pos_q.row + 1'b1, pos_q.col)) begin
              pos_q.row <= pos_q.row + 1'b1;
            end else begin
              state_q <= LOCK;
            end
          end else if (left_i && fits(field_q, pos_q.row, pos_q.col - 1'b1)) begin
            pos_q.col <= pos_q.col - 1'b1;
          end else if (right_i && fits(field_q, pos_q.row, pos_q.col + 1'b1)) begin
            pos_q.col <= pos_q.col + 1'b1;
          end
        end
        LOCK: begin
          // Piece becomes part of the field
          field_q[pos_q.row][pos_q.col]                <= 1'b1;
          field_q[pos_q.row][pos_q.col + 1'b1]         <= 1'b1;
          field_q[pos_q.row + 1'b1][pos_q.col]         <= 1'b1;
          field_q[pos_q.row + 1'b1][pos_q.col + 1'b1]  <= 1'b1;
          clr_row_q <= row_t'(ROWS - 1);
          state_q   <= CLEAR;
        end
        CLEAR: begin
          if (&field_q[clr_row_q]) begin
            // Drop everything above, recheck same index
            for (int i = 1; i < ROWS; i++) begin
              if (row_t'(i) <= clr_row_q) begin
                field_q[i] <= field_q[i - 1];
              end
            end
            field_q[0] <= '0;
            if (score_q != '1) begin
              score_q <= score_q + 1'b1;
            end
          end else if (clr_row_q == '0) begin
            state_q <= SPAWN;
          end else begin
            clr_row_q <= clr_row_q - 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign field_o  = field_q;
  assign status_o = '{pos: pos_q, score: score_q, state: state_q};

endmodule

`default_nettype wire

//--- hdl/tetris_pkg.sv
`default_nettype none

package tetris_pkg;

  // ==========================================================
  // Playfield geometry
  // ==========================================================

  // Field size in cells
  localparam int ROWS = 20;
  localparam int COLS = 10;

  // Row and column indices, row 0 at the top
  typedef logic [4:0] row_t;
  typedef logic [3:0] col_t;

  // Column where every new piece appears
  localparam col_t SPAWN_COL = 4'd4;

  // One row of occupancy, bit n is column n
  typedef logic [COLS-1:0] row_bits_t;
  // Whole field, index 0 is the top row
  typedef row_bits_t [ROWS-1:0] playfield_t;

  // Cleared row count, saturates
  typedef logic [9:0] score_t;

  // ==========================================================
  // Engine state and summary
  // ==========================================================

  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    FALL  = 3'd1,
    LOCK  = 3'd2,
    CLEAR = 3'd3,
    SPAWN = 3'd4,
    OVER  = 3'd5
  } game_state_e;

  // Top-left cell of the 2x2 piece
  // Column sits above row so the status word lines up with the register map
  typedef struct packed {
    col_t col;
    row_t row;
  } piece_pos_t;

  // Bits 21:13 position, 12:3 score, 2:0 state
  typedef struct packed {
    piece_pos_t  pos;
    score_t      score;
    game_state_e state;
  } game_status_t;

endpackage

`default_nettype wire

//--- hdl/tetris_top.sv
`default_nettype none
`timescale 1ns/1ps

module tetris_top #(
  parameter int DEBOUNCE_CYCLES = 250000,
  parameter int TICK_CYCLES     = 12500000
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        btn_left_i,
  input  logic        btn_right_i,
  input  logic        btn_start_i,
  input  logic        btn_speed_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [4:0]  wb_adr_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        red_o,
  output logic        green_o,
  output logic        blue_o,
  output logic        hsync_o,
  output logic        vsync_o
);

  import tetris_pkg::*;
  import video_pkg::*;

  logic         left_press;
  logic         right_press;
  logic         start_press;
  logic         speed_level;
  logic         tick;
  logic         run;
  playfield_t   field;
  game_status_t status;
  vga_sync_t    sync;
  rgb_t         pix;

  // ==========================================================
  // Buttons
  // ==========================================================

  button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) left_debounce (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .pad_i(btn_left_i),
    .press_o(left_press), .level_o()
  );

  button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) right_debounce (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .pad_i(btn_right_i),
    .press_o(right_press), .level_o()
  );

  button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) start_debounce (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .pad_i(btn_start_i),
    .press_o(start_press), .level_o()
  );

  // Speed-up acts while held
  button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) speed_debounce (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .pad_i(btn_speed_i),
    .press_o(), .level_o(speed_level)
  );

  // ==========================================================
  // Game
  // ==========================================================

  // Gravity runs only while a piece falls
  assign run = (status.state == FALL);

  drop_timer #(.TICK_CYCLES(TICK_CYCLES)) timer (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .run_i(run),
    .speed_up_i(speed_level), .score_i(status.score), .tick_o(tick)
  );

  tetris_engine engine (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .start_i(start_press),
    .left_i(left_press), .right_i(right_press), .tick_i(tick),
    .field_o(field), .status_o(status)
  );

  // ==========================================================
  // Display and host bus
  // ==========================================================

  vga_timing vga (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .sync_o(sync)
  );

  pixel_compositor compositor (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .sync_i(sync), .field_i(field),
    .status_i(status), .rgb_o(pix), .hsync_o(hsync_o), .vsync_o(vsync_o)
  );

  assign red_o   = pix.red;
  assign green_o = pix.green;
  assign blue_o  = pix.blue;

  game_regs regs (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_o(wb_dat_o),
    .wb_ack_o(wb_ack_o), .field_i(field), .status_i(status)
  );

endmodule

`default_nettype wire

//--- hdl/vga_timing.sv
`default_nettype none
`timescale 1ns/1ps

module vga_timing (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  output video_pkg::vga_sync_t sync_o
);

  import video_pkg::*;

  // Sync pulse windows
  localparam int HS_START = H_VISIBLE + H_FRONT;
  localparam int HS_END   = HS_START + H_SYNC;
  localparam int VS_START = V_VISIBLE + V_FRONT;
  localparam int VS_END   = VS_START + V_SYNC;

  pix_coord_t h_q;
  pix_coord_t v_q;

  // Pixel counter wraps into the line counter
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      h_q <= '0;
      v_q <= '0;
    end else if (h_q == pix_coord_t'(H_TOTAL - 1)) begin
      h_q <= '0;
      v_q <= (v_q == pix_coord_t'(V_TOTAL - 1)) ? '0 : v_q + 1'b1;
    end else begin
      h_q <= h_q + 1'b1;
    end
  end

  // Decode, registered downstream in the compositor
  assign sync_o = '{
    hsync:   !(h_q >= pix_coord_t'(HS_START) && h_q < pix_coord_t'(HS_END)),
    vsync:   !(v_q >= pix_coord_t'(VS_START) && v_q < pix_coord_t'(VS_END)),
    visible: (h_q < pix_coord_t'(H_VISIBLE)) && (v_q < pix_coord_t'(V_VISIBLE)),
    x:       h_q,
    y:       v_q
  };

endmodule

`default_nettype wire

//--- hdl/video_pkg.sv
`default_nettype none

package video_pkg;

  // ==========================================================
  // 640x480 timing
  // ==========================================================

  // Horizontal, in pixel clocks
  localparam int H_VISIBLE = 640;
  localparam int H_FRONT   = 16;
  localparam int H_SYNC    = 96;
  localparam int H_BACK    = 48;
  localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

  // Vertical, in lines
  localparam int V_VISIBLE = 480;
  localparam int V_FRONT   = 10;
  localparam int V_SYNC    = 2;
  localparam int V_BACK    = 33;
  localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

  // Pixel position on either axis
  typedef logic [9:0] pix_coord_t;

  // One bit per colour channel
  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } rgb_t;

  // Palette
  localparam rgb_t RGB_BLACK = 3'b000;
  localparam rgb_t RGB_RED   = 3'b100;
  localparam rgb_t RGB_GREEN = 3'b010;
  localparam rgb_t RGB_CYAN  = 3'b011;
  localparam rgb_t RGB_WHITE = 3'b111;

  // Sync strobes are active low
  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic       visible;
    pix_coord_t x;
    pix_coord_t y;
  } vga_sync_t;

endpackage

`default_nettype wire

//--- tetris_top.f
hdl/tetris_pkg.sv
hdl/video_pkg.sv
hdl/button_debounce.sv
hdl/drop_timer.sv
hdl/tetris_engine.sv
hdl/vga_timing.sv
hdl/pixel_compositor.sv
hdl/game_regs.sv
hdl/tetris_top.sv
bench/tetris_top_tb.sv
